//--- dma_params.svh
// cluster DMA parameters
// core count, memory widths, length and counter widths, queue depth

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// number of core control ports
`define DMA_NB_CORES 4

// memory word address and data widths
`define DMA_ADDR_WIDTH 16
`define DMA_DATA_WIDTH 32

// transfer length in words
`define DMA_LEN_WIDTH 8

// descriptor queue entries
`define DMA_DESC_DEPTH 4

// per-core done counter width
`define DMA_CNT_WIDTH 8

`endif

//--- dma_pkg.sv
// cluster DMA package
// shared types: core index, address/data/length words,
// transfer descriptor and control register offsets

`include "dma_params.svh"

package dma_pkg;

  typedef logic [$clog2(`DMA_NB_CORES)-1:0] core_idx_t;

  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
  typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;

  // one queued word-copy transfer
  typedef struct packed {
    addr_t     src;
    addr_t     dst;
    len_t      len;
    core_idx_t core;
    logic      irq_en;
  } desc_t;

  // word offsets inside a core control port
  typedef enum logic [1:0] {
    REG_SRC  = 2'd0,
    REG_DST  = 2'd1,
    REG_LEN  = 2'd2,
    REG_DONE = 2'd3
  } ctrl_reg_e;

endpackage

//--- dma_ctrl_decode.sv
// DMA control decode
// round-robin arbiter over the core control ports, per-core staged
// source/destination registers and the shared descriptor queue.
// a LEN write launches a transfer and is held off while the queue is full

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_ctrl_decode (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [`DMA_NB_CORES-1:0]                 cfg_req_i,
  input  logic [`DMA_NB_CORES-1:0]                 cfg_we_i,
  input  logic [`DMA_NB_CORES-1:0][1:0]            cfg_add_i,
  input  dma_pkg::data_t [`DMA_NB_CORES-1:0]       cfg_wdata_i,
  input  logic                                     desc_pop_i,
  input  logic [`DMA_NB_CORES-1:0][`DMA_CNT_WIDTH-1:0] done_cnt_i,
  output logic [`DMA_NB_CORES-1:0]                 cfg_gnt_o,
  output logic [`DMA_NB_CORES-1:0]                 cfg_r_valid_o,
  output dma_pkg::data_t [`DMA_NB_CORES-1:0]       cfg_r_rdata_o,
  output logic                                     desc_valid_o,
  output dma_pkg::desc_t                           desc_o,
  output logic                                     queue_empty_o
);

  import dma_pkg::*;

  localparam int unsigned NB    = `DMA_NB_CORES;
  localparam int unsigned DEPTH = `DMA_DESC_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  core_idx_t             rr_ptr_q;
  core_idx_t             gnt_idx;
  logic                  gnt_found;
  logic [NB-1:0]         eligible;

  logic                  g_we;
  ctrl_reg_e             g_add;
  data_t                 g_wdata;
  data_t                 rd_data;
  logic                  push;

  addr_t                 src_q [NB];
  addr_t                 dst_q [NB];
  logic [NB-1:0]         r_valid_q;
  data_t                 rdata_q;

  desc_t                 queue_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  full;

  assign full          = (count_q == CNT_W'(DEPTH));
  assign queue_empty_o = (count_q == '0);
  assign desc_valid_o  = !queue_empty_o;
  assign desc_o        = queue_q[rd_ptr_q];

  // a LEN write may only win when there is room to push it
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      eligible[i] = cfg_req_i[i] &&
                    !(cfg_we_i[i] && ctrl_reg_e'(cfg_add_i[i]) == REG_LEN && full);
    end
  end

  // first eligible requester at or after the round-robin pointer
  always_comb begin
    core_idx_t idx;
    gnt_found = 1'b0;
    gnt_idx   = rr_ptr_q;
    for (int k = 0; k < NB; k++) begin
      idx = core_idx_t'((int'(rr_ptr_q) + k) % NB);
      if (!gnt_found && eligible[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = idx;
      end
    end
    cfg_gnt_o = '0;
    if (gnt_found) begin
      cfg_gnt_o[gnt_idx] = 1'b1;
    end
  end

  assign g_we    = cfg_we_i[gnt_idx];
  assign g_add   = ctrl_reg_e'(cfg_add_i[gnt_idx]);
  assign g_wdata = cfg_wdata_i[gnt_idx];
  assign push    = gnt_found && g_we && (g_add == REG_LEN);

  // read-back mux, LEN reads as zero
  always_comb begin
    case (g_add)
      REG_SRC:  rd_data = data_t'(src_q[gnt_idx]);
      REG_DST:  rd_data = data_t'(dst_q[gnt_idx]);
      REG_DONE: rd_data = data_t'(done_cnt_i[gnt_idx]);
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q  <= '0;
      r_valid_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      r_valid_q <= cfg_gnt_o;
      if (gnt_found) begin
        rr_ptr_q <= core_idx_t'((int'(gnt_idx) + 1) % NB);
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (desc_pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, desc_pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // staged addresses, response data and queue storage
  always_ff @(posedge clk_i) begin
    if (gnt_found) begin
      rdata_q <= g_we ? '0 : rd_data;
      if (g_we && g_add == REG_SRC) begin
        src_q[gnt_idx] <= g_wdata[`DMA_ADDR_WIDTH-1:0];
      end
      if (g_we && g_add == REG_DST) begin
        dst_q[gnt_idx] <= g_wdata[`DMA_ADDR_WIDTH-1:0];
      end
    end
    if (push) begin
      queue_q[wr_ptr_q] <= '{src:    src_q[gnt_idx],
                             dst:    dst_q[gnt_idx],
                             len:    g_wdata[`DMA_LEN_WIDTH-1:0],
                             core:   gnt_idx,
                             irq_en: g_wdata[`DMA_DATA_WIDTH-1]};
    end
  end

  assign cfg_r_valid_o = r_valid_q;

  // response data goes to every port, r_valid selects the owner
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      cfg_r_rdata_o[i] = rdata_q;
    end
  end

endmodule

//--- dma_copy_engine.sv
// DMA copy engine
// pops descriptors from the queue and copies them word by word,
// one read then one write per word on the memory master port,
// and reports each finished descriptor with its core and irq flag

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_copy_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               desc_valid_i,
  input  dma_pkg::desc_t     desc_i,
  input  dma_pkg::data_t     mem_rdata_i,
  output logic               desc_pop_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output dma_pkg::addr_t     mem_addr_o,
  output dma_pkg::data_t     mem_wdata_o,
  output logic               done_o,
  output dma_pkg::core_idx_t done_core_o,
  output logic               done_irq_o,
  output logic               active_o
);

  import dma_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e    state_q;
  logic      done_q;

  addr_t     src_q;
  addr_t     dst_q;
  len_t      remain_q;
  core_idx_t core_q;
  logic      irq_q;

  logic      last_write;

  assign desc_pop_o = (state_q == ST_IDLE) && desc_valid_i;
  assign last_write = (state_q == ST_WRITE) && (remain_q == len_t'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      // zero length completes straight from the accept cycle
      done_q <= (desc_pop_o && desc_i.len == '0) || last_write;
      case (state_q)
        ST_IDLE: begin
          if (desc_pop_o && desc_i.len != '0) begin
            state_q <= ST_READ;
          end
        end
        ST_READ: begin
          state_q <= ST_WRITE;
        end
        ST_WRITE: begin
          state_q <= last_write ? ST_IDLE : ST_READ;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // current transfer, loaded on accept and stepped after each write
  always_ff @(posedge clk_i) begin
    if (desc_pop_o) begin
      src_q    <= desc_i.src;
      dst_q    <= desc_i.dst;
      remain_q <= desc_i.len;
      core_q   <= desc_i.core;
      irq_q    <= desc_i.irq_en;
    end else if (state_q == ST_WRITE) begin
      src_q    <= src_q + 1'b1;
      dst_q    <= dst_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  assign mem_req_o   = (state_q == ST_READ) || (state_q == ST_WRITE);
  assign mem_we_o    = (state_q == ST_WRITE);
  assign mem_addr_o  = (state_q == ST_WRITE) ? dst_q : src_q;
  // read data lands in the write cycle
  assign mem_wdata_o = mem_rdata_i;

  assign done_o      = done_q;
  assign done_core_o = core_q;
  assign done_irq_o  = irq_q;
  assign active_o    = (state_q != ST_IDLE) || done_q;

endmodule

//--- dma_term_unit.sv
// DMA termination unit
// turns engine completions into one-cycle per-core event and
// interrupt pulses and keeps a wrapping done counter per core

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_term_unit (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         done_i,
  input  dma_pkg::core_idx_t                           done_core_i,
  input  logic                                         done_irq_i,
  output logic [`DMA_NB_CORES-1:0]                     term_event_o,
  output logic [`DMA_NB_CORES-1:0]                     term_irq_o,
  output logic [`DMA_NB_CORES-1:0][`DMA_CNT_WIDTH-1:0] done_cnt_o
);

  import dma_pkg::*;

  localparam int unsigned NB = `DMA_NB_CORES;

  logic [NB-1:0]                     done_oh;
  logic [NB-1:0]                     event_q;
  logic [NB-1:0]                     irq_q;
  logic [NB-1:0][`DMA_CNT_WIDTH-1:0] cnt_q;

  // one-hot of the finishing core
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      done_oh[i] = done_i && (done_core_i == core_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      event_q <= '0;
      irq_q   <= '0;
      cnt_q   <= '0;
    end else begin
      event_q <= done_oh;
      irq_q   <= done_irq_i ? done_oh : '0;
      for (int i = 0; i < NB; i++) begin
        if (done_oh[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign term_event_o = event_q;
  assign term_irq_o   = irq_q;
  assign done_cnt_o   = cnt_q;

endmodule

//--- dma_cluster_top.sv
// cluster DMA controller top
// per-core control ports feed the decode block and descriptor queue,
// the copy engine drives the memory port and the termination unit
// raises per-core events, interrupts and done counts

`timescale 1ns/10ps
`include "dma_params.svh"

module dma_cluster_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [`DMA_NB_CORES-1:0]           cfg_req_i,
  input  logic [`DMA_NB_CORES-1:0]           cfg_we_i,
  input  logic [`DMA_NB_CORES-1:0][1:0]      cfg_add_i,
  input  dma_pkg::data_t [`DMA_NB_CORES-1:0] cfg_wdata_i,
  input  dma_pkg::data_t                     mem_rdata_i,
  output logic [`DMA_NB_CORES-1:0]           cfg_gnt_o,
  output logic [`DMA_NB_CORES-1:0]           cfg_r_valid_o,
  output dma_pkg::data_t [`DMA_NB_CORES-1:0] cfg_r_rdata_o,
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output dma_pkg::addr_t                     mem_addr_o,
  output dma_pkg::data_t                     mem_wdata_o,
  output logic [`DMA_NB_CORES-1:0]           term_event_o,
  output logic [`DMA_NB_CORES-1:0]           term_irq_o,
  output logic                               busy_o
);

  import dma_pkg::*;

  desc_t     desc;
  logic      desc_valid;
  logic      desc_pop;
  logic      queue_empty;

  logic      done;
  core_idx_t done_core;
  logic      done_irq;
  logic      active;

  logic [`DMA_NB_CORES-1:0][`DMA_CNT_WIDTH-1:0] done_cnt;

  dma_ctrl_decode u_dma_ctrl_decode (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cfg_req_i     ( cfg_req_i     ),
    .cfg_we_i      ( cfg_we_i      ),
    .cfg_add_i     ( cfg_add_i     ),
    .cfg_wdata_i   ( cfg_wdata_i   ),
    .desc_pop_i    ( desc_pop      ),
    .done_cnt_i    ( done_cnt      ),
    .cfg_gnt_o     ( cfg_gnt_o     ),
    .cfg_r_valid_o ( cfg_r_valid_o ),
    .cfg_r_rdata_o ( cfg_r_rdata_o ),
    .desc_valid_o  ( desc_valid    ),
    .desc_o        ( desc          ),
    .queue_empty_o ( queue_empty   )
  );

  dma_copy_engine u_dma_copy_engine (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .desc_valid_i ( desc_valid  ),
    .desc_i       ( desc        ),
    .mem_rdata_i  ( mem_rdata_i ),
    .desc_pop_o   ( desc_pop    ),
    .mem_req_o    ( mem_req_o   ),
    .mem_we_o     ( mem_we_o    ),
    .mem_addr_o   ( mem_addr_o  ),
    .mem_wdata_o  ( mem_wdata_o ),
    .done_o       ( done        ),
    .done_core_o  ( done_core   ),
    .done_irq_o   ( done_irq    ),
    .active_o     ( active      )
  );

  dma_term_unit u_dma_term_unit (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .done_i       ( done         ),
    .done_core_i  ( done_core    ),
    .done_irq_i   ( done_irq     ),
    .term_event_o ( term_event_o ),
    .term_irq_o   ( term_irq_o   ),
    .done_cnt_o   ( done_cnt     )
  );

  // queued or in-flight work
  assign busy_o = active || !queue_empty;

endmodule

//--- tb_dma_cluster.sv
// cluster DMA controller testbench
// directed tests on the per-core control ports with a one-cycle
// latency memory model, event monitor and copy checks

`timescale 1ns/10ps
`include "dma_params.svh"

module tb_dma_cluster;

  localparam int NB         = `DMA_NB_CORES;
  localparam int MAX_CYCLES = 20000;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic [NB-1:0]         cfg_req;
  logic [NB-1:0]         cfg_we;
  logic [NB-1:0][1:0]    cfg_add;
  logic [NB-1:0][31:0]   cfg_wdata;
  logic [NB-1:0]         cfg_gnt;
  logic [NB-1:0]         cfg_r_valid;
  logic [NB-1:0][31:0]   cfg_r_rdata;
  logic                  mem_req;
  logic                  mem_we;
  logic [15:0]           mem_addr;
  logic [31:0]           mem_wdata;
  logic [31:0]           mem_rdata;
  logic [NB-1:0]         term_event;
  logic [NB-1:0]         term_irq;
  logic                  busy;

  logic [31:0] mem [65536];
  logic [31:0] ref_mem [65536];
  logic [15:0] write_log [$];
  logic [31:0] lcg_state;
  int          errors = 0;
  int          cycles = 0;
  int          ev_cnt [NB];
  int          irq_cnt [NB];
  int          exp_ev [NB];
  int          exp_irq [NB];

  dma_cluster_top u_dma_cluster_top (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .cfg_req_i     ( cfg_req     ),
    .cfg_we_i      ( cfg_we      ),
    .cfg_add_i     ( cfg_add     ),
    .cfg_wdata_i   ( cfg_wdata   ),
    .mem_rdata_i   ( mem_rdata   ),
    .cfg_gnt_o     ( cfg_gnt     ),
    .cfg_r_valid_o ( cfg_r_valid ),
    .cfg_r_rdata_o ( cfg_r_rdata ),
    .mem_req_o     ( mem_req     ),
    .mem_we_o      ( mem_we      ),
    .mem_addr_o    ( mem_addr    ),
    .mem_wdata_o   ( mem_wdata   ),
    .term_event_o  ( term_event  ),
    .term_irq_o    ( term_irq    ),
    .busy_o        ( busy        )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // memory model, read data one cycle after the strobe
  always @(posedge clk_i) begin
    if (mem_req && mem_we) begin
      mem[mem_addr] <= mem_wdata;
      write_log.push_back(mem_addr);
    end else if (mem_req) begin
      mem_rdata <= mem[mem_addr];
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, transfers did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // event monitor and per-cycle protocol checks
  always @(negedge clk_i) begin
    for (int c = 0; c < NB; c++) begin
      if (term_event[c]) ev_cnt[c]++;
      if (term_irq[c]) irq_cnt[c]++;
    end
    assert ($countones(cfg_gnt) <= 1) else begin
      errors++;
      $display("error at %0t: more than one control port granted in a cycle", $time);
    end
    assert ((cfg_gnt & ~cfg_req) == '0) else begin
      errors++;
      $display("error at %0t: grant given to a port without a request", $time);
    end
    assert ((term_irq & ~term_event) == '0) else begin
      errors++;
      $display("error at %0t: interrupt raised without its event", $time);
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic cfg_access(input int core, input logic we, input logic [1:0] add,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int waits);
    waits = 0;
    @(posedge clk_i);
    cfg_req[core]   <= 1'b1;
    cfg_we[core]    <= we;
    cfg_add[core]   <= add;
    cfg_wdata[core] <= wdata;
    @(negedge clk_i);
    while (!cfg_gnt[core]) begin
      waits++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    cfg_req[core] <= 1'b0;
    @(negedge clk_i);
    assert (cfg_r_valid[core]) else begin
      errors++;
      $display("error at %0t: no response on port %0d after its grant", $time, core);
    end
    rdata = cfg_r_rdata[core];
  endtask

  task automatic cfg_write(input int core, input logic [1:0] add, input logic [31:0] wdata,
                           output int waits);
    logic [31:0] rdata;
    cfg_access(core, 1'b1, add, wdata, rdata, waits);
    check_eq($sformatf("cfg_r_rdata_o[%0d]", core), 32'h0, rdata);
  endtask

  task automatic cfg_read(input int core, input logic [1:0] add, output logic [31:0] rdata);
    int waits;
    cfg_access(core, 1'b0, add, 32'h0, rdata, waits);
  endtask

  // SRC, DST, then LEN with irq_en in bit 31
  task automatic launch(input int core, input logic [15:0] src, input logic [15:0] dst,
                        input logic [7:0] len, input logic irq, output int len_waits);
    int waits;
    cfg_write(core, 2'd0, {16'h0, src}, waits);
    cfg_write(core, 2'd1, {16'h0, dst}, waits);
    cfg_write(core, 2'd2, {irq, 23'h0, len}, len_waits);
    exp_ev[core]++;
    if (irq) exp_irq[core]++;
  endtask

  task automatic wait_events(input int core);
    while (ev_cnt[core] < exp_ev[core]) @(negedge clk_i);
  endtask

  // busy must drop and no late event may follow
  task automatic wait_idle();
    int total;
    while (busy) @(negedge clk_i);
    total = ev_cnt[0] + ev_cnt[1] + ev_cnt[2] + ev_cnt[3];
    repeat (20) @(negedge clk_i);
    check_eq("busy_o", 32'h0, {31'h0, busy});
    check_eq("term_event_o total", total, ev_cnt[0] + ev_cnt[1] + ev_cnt[2] + ev_cnt[3]);
  endtask

  task automatic check_copy(input logic [15:0] src, input logic [15:0] dst, input int len);
    logic [15:0] s;
    logic [15:0] d;
    for (int i = 0; i < len; i++) begin
      s = src + 16'(i);
      d = dst + 16'(i);
      check_eq($sformatf("mem[0x%04h]", d), ref_mem[s], mem[d]);
    end
  endtask

  task automatic register_readback();
    logic [31:0] rd;
    int waits;
    for (int c = 0; c < NB; c++) begin
      cfg_write(c, 2'd0, 32'h1000 + 32'(c * 'h111), waits);
      cfg_write(c, 2'd1, 32'hA000 + 32'(c * 'h222), waits);
      cfg_read(c, 2'd0, rd);
      check_eq($sformatf("REG_SRC[%0d]", c), 32'h1000 + 32'(c * 'h111), rd);
      cfg_read(c, 2'd1, rd);
      check_eq($sformatf("REG_DST[%0d]", c), 32'hA000 + 32'(c * 'h222), rd);
      cfg_read(c, 2'd3, rd);
      check_eq($sformatf("REG_DONE[%0d]", c), 32'h0, rd);
    end
  endtask

  task automatic single_copy();
    logic [31:0] rd;
    int waits;
    int nwr;
    nwr = write_log.size();
    launch(0, 16'h0100, 16'h8100, 8'd16, 1'b0, waits);
    check_eq("busy_o", 32'h1, {31'h0, busy});
    wait_events(0);
    wait_idle();
    check_copy(16'h0100, 16'h8100, 16);
    check_eq("memory writes", 32'd16, 32'(write_log.size() - nwr));
    check_eq("term_irq_o[0] count", 32'(exp_irq[0]), 32'(irq_cnt[0]));
    cfg_read(0, 2'd3, rd);
    check_eq("REG_DONE[0]", 32'h1, rd);
  endtask

  task automatic irq_and_zero_len();
    int waits;
    int nwr;
    launch(2, 16'h0200, 16'h8200, 8'd4, 1'b1, waits);
    wait_events(2);
    wait_idle();
    check_copy(16'h0200, 16'h8200, 4);
    for (int c = 0; c < NB; c++) begin
      check_eq($sformatf("term_irq_o[%0d] count", c), 32'(exp_irq[c]), 32'(irq_cnt[c]));
    end
    nwr = write_log.size();
    launch(1, 16'h0300, 16'h8300, 8'd0, 1'b0, waits);
    wait_events(1);
    wait_idle();
    check_eq("memory writes", 32'd0, 32'(write_log.size() - nwr));
    check_eq("term_event_o[1] count", 32'(exp_ev[1]), 32'(ev_cnt[1]));
  endtask

  task automatic concurrent_cores();
    int w [NB];
    fork
      launch(0, 16'h0400, 16'h8400, 8'd8, 1'b0, w[0]);
      launch(1, 16'h0440, 16'h8440, 8'd9, 1'b0, w[1]);
      launch(2, 16'h0480, 16'h8480, 8'd10, 1'b0, w[2]);
      launch(3, 16'h04C0, 16'h84C0, 8'd11, 1'b0, w[3]);
    join
    for (int c = 0; c < NB; c++) wait_events(c);
    wait_idle();
    for (int c = 0; c < NB; c++) begin
      check_copy(16'h0400 + 16'(c * 'h40), 16'h8400 + 16'(c * 'h40), 8 + c);
      check_eq($sformatf("term_event_o[%0d] count", c), 32'(exp_ev[c]), 32'(ev_cnt[c]));
    end
  endtask

  // six launches against a four-entry queue, writes must follow launch order
  task automatic queue_backpressure();
    int waits;
    int max_waits;
    max_waits = 0;
    write_log.delete();
    for (int k = 0; k < 6; k++) begin
      launch(3, 16'h1000 + 16'(32 * k), 16'h9000 + 16'(32 * k), 8'd32, 1'b0, waits);
      if (waits > max_waits) max_waits = waits;
    end
    wait_events(3);
    wait_idle();
    assert (max_waits > 0) else begin
      errors++;
      $display("error at %0t: LEN writes were never held back by a full queue", $time);
    end
    check_eq("memory writes", 32'd192, 32'(write_log.size()));
    for (int j = 0; j < write_log.size() && j < 192; j++) begin
      check_eq($sformatf("write address %0d", j), 32'h9000 + 32'(j), {16'h0, write_log[j]});
    end
    for (int k = 0; k < 6; k++) begin
      check_copy(16'h1000 + 16'(32 * k), 16'h9000 + 16'(32 * k), 32);
    end
  endtask

  initial begin
    logic [31:0] rd;
    rst_n_i   = 1'b0;
    cfg_req   = '0;
    cfg_we    = '0;
    cfg_add   = '0;
    cfg_wdata = '0;
    mem_rdata = '0;
    lcg_state = 32'd18764;
    for (int a = 0; a < 65536; a++) begin
      mem[a]     = lcg_next();
      ref_mem[a] = mem[a];
    end
    for (int c = 0; c < NB; c++) begin
      ev_cnt[c]  = 0;
      irq_cnt[c] = 0;
      exp_ev[c]  = 0;
      exp_irq[c] = 0;
    end
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq("busy_o", 32'h0, {31'h0, busy});
    register_readback();
    single_copy();
    irq_and_zero_len();
    concurrent_cores();
    queue_backpressure();
    for (int c = 0; c < NB; c++) begin
      check_eq($sformatf("term_event_o[%0d] count", c), 32'(exp_ev[c]), 32'(ev_cnt[c]));
      check_eq($sformatf("term_irq_o[%0d] count", c), 32'(exp_irq[c]), 32'(irq_cnt[c]));
      cfg_read(c, 2'd3, rd);
      check_eq($sformatf("REG_DONE[%0d]", c), 32'(exp_ev[c] % 256), rd);
    end
    $display("errors %0d, events %0d %0d %0d %0d, interrupts %0d %0d %0d %0d", errors,
             ev_cnt[0], ev_cnt[1], ev_cnt[2], ev_cnt[3],
             irq_cnt[0], irq_cnt[1], irq_cnt[2], irq_cnt[3]);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
dma_pkg.sv
dma_ctrl_decode.sv
dma_copy_engine.sv
dma_term_unit.sv
dma_cluster_top.sv
tb_dma_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_cluster
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
